// ==== design/coh_pkg.sv ====
package coh_pkg;

    localparam int msg_bits = 3;
    localparam int state_bits = 2;

    // forwards that the handler serves directly from the array.
    typedef enum logic [msg_bits-1:0] {
        fwd_inv_spdx  = 3'd0,
        fwd_req_o     = 3'd1,
        fwd_req_odata = 3'd2,
        fwd_req_v     = 3'd3,
        fwd_rvk_o     = 3'd4,
        fwd_wtfwd     = 3'd5
    } fwd_msg_t;

    typedef enum logic [msg_bits-1:0] {
        inv_ack   = 3'd0,
        rsp_o     = 3'd1,
        rsp_odata = 3'd2,
        rsp_v     = 3'd3,
        rsp_rvk_o = 3'd4,
        rsp_nack  = 3'd5
    } rsp_msg_t;

    typedef enum logic [state_bits-1:0] {
        spx_i = 2'd0, // invalid.
        spx_s = 2'd1, // shared.
        spx_r = 2'd2  // registered, the word is owned here.
    } word_state_t;

endpackage

// ==== design/cache_cfg_pkg.sv ====
package cache_cfg_pkg;

    localparam int l2_sets = 16;
    localparam int l2_ways = 2;
    localparam int words_per_line = 4;
    localparam int bits_per_word = 32;
    localparam int set_bits = 4;
    localparam int tag_bits = 8;
    localparam int addr_bits = 12; // line address, tag above set.
    localparam int req_id_bits = 4;

    typedef logic [addr_bits-1:0] line_addr_t;
    typedef logic [set_bits-1:0] l2_set_t;
    typedef logic [$clog2(l2_ways)-1:0] l2_way_t;
    typedef logic [tag_bits-1:0] l2_tag_t;
    typedef logic [words_per_line-1:0] word_mask_t;
    typedef logic [words_per_line-1:0][bits_per_word-1:0] line_t;
    typedef coh_pkg::word_state_t [words_per_line-1:0] line_states_t;
    typedef logic [req_id_bits-1:0] req_id_t;

    function automatic l2_set_t addr_set(input line_addr_t addr);
        return addr[set_bits-1:0];
    endfunction

    function automatic l2_tag_t addr_tag(input line_addr_t addr);
        return addr[addr_bits-1 -: tag_bits];
    endfunction

endpackage

// ==== design/cache_port_if.sv ====
interface cache_port_if;
    import cache_cfg_pkg::*;

    logic req;
    logic we;
    l2_set_t set;
    l2_way_t way;
    l2_tag_t wr_tag;
    line_states_t wr_states;
    line_t wr_line;
    logic gnt;
    l2_tag_t [l2_ways-1:0] rd_tags;       // all ways of the set, one cycle after set.
    line_states_t [l2_ways-1:0] rd_states;
    line_t [l2_ways-1:0] rd_lines;

    modport client (
        output req, we, set, way, wr_tag, wr_states, wr_line,
        input  gnt, rd_tags, rd_states, rd_lines
    );

    modport arbiter (
        input  req, we, set, way, wr_tag, wr_states, wr_line,
        output gnt, rd_tags, rd_states, rd_lines
    );

endinterface

// ==== design/sram_bank.sv ====
module sram_bank #(
    parameter type data_t = logic
) (
    input  logic clk,
    input  logic rst,
    input  cache_cfg_pkg::l2_set_t set_i,
    input  logic we_i,
    input  logic wr_all_i,
    input  cache_cfg_pkg::l2_way_t way_i,
    input  data_t wdata_i,
    output data_t [cache_cfg_pkg::l2_ways-1:0] rdata_o
);
    import cache_cfg_pkg::*;

    data_t [l2_ways-1:0] mem_q [l2_sets];

    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int w = 0; w < l2_ways; w++) begin
                if (wr_all_i || way_i == l2_way_t'(w)) begin
                    mem_q[set_i][w] <= wdata_i;
                end
            end
        end
        rdata_o <= mem_q[set_i]; // a write in the same cycle shows up one read later.
    end

    a_write_set_known: assert property (@(posedge clk) disable iff (!rst)
        we_i |-> !$isunknown(set_i));

endmodule

// ==== design/cache_arbiter.sv ====
module cache_arbiter (
    input  logic clk,
    input  logic rst,
    cache_port_if.arbiter eng,
    cache_port_if.arbiter fil,
    output logic ready_o
);
    import coh_pkg::*;
    import cache_cfg_pkg::*;

    typedef enum logic [1:0] {own_none, own_eng, own_fil} owner_t;

    owner_t owner_q;
    owner_t cur;
    logic sweep_q;
    l2_set_t sweep_set_q;
    l2_set_t bank_set;
    l2_way_t bank_way;
    logic bank_we;
    l2_tag_t bank_tag;
    line_states_t bank_states;
    line_t bank_line;
    logic states_we;
    line_states_t states_wdata;
    l2_tag_t [l2_ways-1:0] tag_rd;
    line_states_t [l2_ways-1:0] states_rd;
    line_t [l2_ways-1:0] line_rd;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sweep_q <= 1'b1;
            sweep_set_q <= '0;
        end else if (sweep_q) begin
            sweep_set_q <= sweep_set_q + 1'b1;
            if (sweep_set_q == l2_set_t'(l2_sets - 1)) begin
                sweep_q <= 1'b0;
            end
        end
    end

    assign ready_o = !sweep_q;

    // a holder keeps the array until it writes or drops req.
    always_comb begin
        cur = own_none;
        if (owner_q == own_eng && eng.req) begin
            cur = own_eng;
        end else if (owner_q == own_fil && fil.req) begin
            cur = own_fil;
        end else if (ready_o && eng.req) begin
            cur = own_eng;
        end else if (ready_o && fil.req) begin
            cur = own_fil;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            owner_q <= own_none;
        end else begin
            owner_q <= bank_we ? own_none : cur;
        end
    end

    always_comb begin
        if (cur == own_fil) begin
            bank_set = fil.set;
            bank_way = fil.way;
            bank_tag = fil.wr_tag;
            bank_states = fil.wr_states;
            bank_line = fil.wr_line;
        end else begin
            bank_set = sweep_q ? sweep_set_q : eng.set;
            bank_way = eng.way;
            bank_tag = eng.wr_tag;
            bank_states = eng.wr_states;
            bank_line = eng.wr_line;
        end
        bank_we = (cur == own_eng && eng.we) || (cur == own_fil && fil.we);
        states_we = sweep_q || bank_we;
        states_wdata = sweep_q ? line_states_t'({words_per_line{spx_i}}) : bank_states;
    end

    sram_bank #(.data_t(l2_tag_t)) u_tags (
        .clk(clk),
        .rst(rst),
        .set_i(bank_set),
        .we_i(bank_we),
        .wr_all_i(1'b0),
        .way_i(bank_way),
        .wdata_i(bank_tag),
        .rdata_o(tag_rd)
    );

    sram_bank #(.data_t(line_states_t)) u_states (
        .clk(clk),
        .rst(rst),
        .set_i(bank_set),
        .we_i(states_we),
        .wr_all_i(sweep_q),
        .way_i(bank_way),
        .wdata_i(states_wdata),
        .rdata_o(states_rd)
    );

    sram_bank #(.data_t(line_t)) u_lines (
        .clk(clk),
        .rst(rst),
        .set_i(bank_set),
        .we_i(bank_we),
        .wr_all_i(1'b0),
        .way_i(bank_way),
        .wdata_i(bank_line),
        .rdata_o(line_rd)
    );

    assign eng.gnt = cur == own_eng;
    assign fil.gnt = cur == own_fil;
    assign eng.rd_tags = tag_rd;
    assign eng.rd_states = states_rd;
    assign eng.rd_lines = line_rd;
    assign fil.rd_tags = tag_rd;
    assign fil.rd_states = states_rd;
    assign fil.rd_lines = line_rd;

    // a client only writes while it still holds the grant it was given.
    a_write_granted: assert property (@(posedge clk) disable iff (!rst)
        (!eng.we || eng.gnt) && (!fil.we || fil.gnt));

endmodule

// ==== design/line_filler.sv ====
module line_filler (
    input  logic clk,
    input  logic rst,
    input  logic fill_valid_i,
    output logic fill_ready_o,
    input  cache_cfg_pkg::line_addr_t fill_addr_i,
    input  cache_cfg_pkg::line_t fill_line_i,
    input  cache_cfg_pkg::line_states_t fill_states_i,
    cache_port_if.client mem
);
    import cache_cfg_pkg::*;

    logic busy_q;
    logic accept;
    line_addr_t addr_q;
    line_t line_q;
    line_states_t states_q;
    l2_way_t [l2_sets-1:0] victim_q;

    assign fill_ready_o = !busy_q && mem.gnt;
    assign accept = fill_valid_i && fill_ready_o;

    // the request stays up from the offer until the write.
    assign mem.req = busy_q || fill_valid_i;
    assign mem.we = busy_q;
    assign mem.set = addr_set(addr_q);
    assign mem.way = victim_q[addr_set(addr_q)];
    assign mem.wr_tag = addr_tag(addr_q);
    assign mem.wr_states = states_q;
    assign mem.wr_line = line_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy_q <= 1'b0;
            victim_q <= '0;
        end else if (busy_q) begin
            if (mem.gnt) begin
                busy_q <= 1'b0;
                victim_q[addr_set(addr_q)] <= victim_q[addr_set(addr_q)] + 1'b1;
            end
        end else if (accept) begin
            busy_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= fill_addr_i;
            line_q <= fill_line_i;
            states_q <= fill_states_i;
        end
    end

endmodule

// ==== design/fwd_engine.sv ====
module fwd_engine (
    input  logic clk,
    input  logic rst,
    input  logic array_ready_i,
    input  logic fwd_valid_i,
    output logic fwd_ready_o,
    input  coh_pkg::fwd_msg_t fwd_msg_i,
    input  cache_cfg_pkg::line_addr_t fwd_addr_i,
    input  cache_cfg_pkg::req_id_t fwd_req_id_i,
    input  cache_cfg_pkg::word_mask_t fwd_mask_i,
    input  cache_cfg_pkg::line_t fwd_line_i,
    output logic rsp_valid_o,
    input  logic rsp_ready_i,
    output coh_pkg::rsp_msg_t rsp_msg_o,
    output cache_cfg_pkg::req_id_t rsp_req_id_o,
    output logic rsp_to_req_o,
    output cache_cfg_pkg::line_addr_t rsp_addr_o,
    output cache_cfg_pkg::line_t rsp_line_o,
    output cache_cfg_pkg::word_mask_t rsp_mask_o,
    output logic inval_valid_o,
    output cache_cfg_pkg::line_addr_t inval_addr_o,
    cache_port_if.client mem
);
    import coh_pkg::*;
    import cache_cfg_pkg::*;

    typedef enum logic [2:0] {st_idle, st_lookup, st_update, st_ack, st_nack} fsm_t;

    fsm_t state_q;
    fwd_msg_t msg_q;
    line_addr_t addr_q;
    req_id_t id_q;
    word_mask_t mask_q;
    line_t line_q;
    word_mask_t nack_mask_q;
    logic rsp_valid_q;
    logic inval_q;
    rsp_msg_t rsp_msg_q;
    req_id_t rsp_id_q;
    logic rsp_to_req_q;
    line_t rsp_line_q;
    word_mask_t rsp_mask_q;
    logic hit;
    l2_way_t hit_way;
    line_states_t cur_st;
    line_states_t new_st;
    line_t cur_ln;
    line_t new_ln;
    word_mask_t r_mask;
    word_mask_t ack_c;
    word_mask_t nack_c;
    rsp_msg_t ack_msg_c;
    req_id_t ack_id_c;
    logic ack_to_req_c;
    line_t ack_line_c;
    logic inval_c;
    logic accept;
    logic rsp_taken;
    logic use_ack;
    logic load_rsp;

    // lowest way with a matching tag and a live word.
    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = l2_ways - 1; w >= 0; w--) begin
            if (mem.rd_tags[w] == addr_tag(addr_q)) begin
                for (int i = 0; i < words_per_line; i++) begin
                    if (mem.rd_states[w][i] != spx_i) begin
                        hit = 1'b1;
                        hit_way = l2_way_t'(w);
                    end
                end
            end
        end
    end

    always_comb begin
        cur_st = mem.rd_states[hit_way];
        cur_ln = mem.rd_lines[hit_way];
        new_st = cur_st;
        new_ln = cur_ln;
        for (int i = 0; i < words_per_line; i++) begin
            r_mask[i] = hit && mask_q[i] && cur_st[i] == spx_r;
        end
        ack_c = r_mask;
        nack_c = '0;
        ack_msg_c = rsp_o;
        ack_id_c = id_q;
        ack_to_req_c = 1'b1;
        ack_line_c = '0;
        inval_c = 1'b1;
        if (msg_q inside {fwd_req_o, fwd_req_odata, fwd_rvk_o}) begin
            for (int i = 0; i < words_per_line; i++) begin
                if (r_mask[i]) new_st[i] = spx_i; // ownership leaves with the response.
            end
        end
        case (msg_q)
            fwd_inv_spdx: begin
                for (int i = 0; i < words_per_line; i++) begin
                    if (hit && mask_q[i] && cur_st[i] == spx_s) new_st[i] = spx_i;
                end
                ack_c = '1;
                ack_msg_c = inv_ack;
                ack_id_c = '0;
                ack_to_req_c = 1'b0;
            end
            fwd_req_o: begin
            end
            fwd_req_odata: begin
                ack_msg_c = rsp_odata;
                ack_line_c = cur_ln;
            end
            fwd_rvk_o: begin
                ack_msg_c = rsp_rvk_o;
                ack_to_req_c = 1'b0;
                ack_line_c = cur_ln;
            end
            fwd_req_v: begin
                ack_msg_c = rsp_v;
                ack_line_c = cur_ln;
                nack_c = mask_q & ~r_mask;
                inval_c = 1'b0;
            end
            default: begin
                for (int i = 0; i < words_per_line; i++) begin
                    if (r_mask[i]) new_ln[i] = line_q[i]; // write-through data lands here.
                end
                nack_c = mask_q & ~r_mask;
                inval_c = 1'b0;
            end
        endcase
    end

    assign accept = fwd_valid_i && fwd_ready_o;
    assign rsp_taken = rsp_valid_q && rsp_ready_i;
    assign use_ack = state_q == st_update && ack_c != '0;
    assign load_rsp = state_q == st_update ||
                      (state_q == st_ack && rsp_taken && nack_mask_q != '0);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= st_idle;
            rsp_valid_q <= 1'b0;
            inval_q <= 1'b0;
        end else begin
            inval_q <= state_q == st_update && inval_c;
            case (state_q)
                st_idle: if (accept) state_q <= st_lookup;
                st_lookup: if (mem.gnt) state_q <= st_update;
                st_update: begin
                    rsp_valid_q <= ack_c != '0 || nack_c != '0;
                    state_q <= ack_c != '0 ? st_ack : st_nack;
                end
                st_ack: begin
                    if (rsp_taken && nack_mask_q != '0) begin
                        state_q <= st_nack;
                    end else if (rsp_taken) begin
                        rsp_valid_q <= 1'b0;
                        state_q <= st_idle;
                    end
                end
                default: begin
                    if (rsp_taken || !rsp_valid_q) begin
                        rsp_valid_q <= 1'b0;
                        state_q <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            msg_q <= fwd_msg_i;
            addr_q <= fwd_addr_i;
            id_q <= fwd_req_id_i;
            mask_q <= fwd_mask_i;
            line_q <= fwd_line_i;
        end
        if (state_q == st_update) nack_mask_q <= nack_c;
        if (load_rsp) begin
            rsp_msg_q <= use_ack ? ack_msg_c : rsp_nack;
            rsp_id_q <= use_ack ? ack_id_c : id_q;
            rsp_to_req_q <= use_ack ? ack_to_req_c : 1'b1;
            rsp_line_q <= use_ack ? ack_line_c : '0;
            rsp_mask_q <= use_ack ? ack_c : (state_q == st_update ? nack_c : nack_mask_q);
        end
    end

    assign mem.req = state_q == st_lookup || state_q == st_update;
    assign mem.we = state_q == st_update && hit;
    assign mem.set = addr_set(addr_q);
    assign mem.way = hit_way;
    assign mem.wr_tag = addr_tag(addr_q);
    assign mem.wr_states = new_st;
    assign mem.wr_line = new_ln;

    assign fwd_ready_o = state_q == st_idle && array_ready_i;
    assign rsp_valid_o = rsp_valid_q;
    assign rsp_msg_o = rsp_msg_q;
    assign rsp_req_id_o = rsp_id_q;
    assign rsp_to_req_o = rsp_to_req_q;
    assign rsp_addr_o = addr_q;
    assign rsp_line_o = rsp_line_q;
    assign rsp_mask_o = rsp_mask_q;
    assign inval_valid_o = inval_q;
    assign inval_addr_o = addr_q;

    a_rsp_stable: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o &&
        $stable({rsp_msg_o, rsp_req_id_o, rsp_to_req_o, rsp_addr_o, rsp_line_o, rsp_mask_o}));

endmodule

// ==== design/l2_fwd_top.sv ====
module l2_fwd_top (
    input  logic clk,
    input  logic rst,
    input  logic fwd_valid_i,
    output logic fwd_ready_o,
    input  coh_pkg::fwd_msg_t fwd_msg_i,
    input  cache_cfg_pkg::line_addr_t fwd_addr_i,
    input  cache_cfg_pkg::req_id_t fwd_req_id_i,
    input  cache_cfg_pkg::word_mask_t fwd_mask_i,
    input  cache_cfg_pkg::line_t fwd_line_i,
    output logic rsp_valid_o,
    input  logic rsp_ready_i,
    output coh_pkg::rsp_msg_t rsp_msg_o,
    output cache_cfg_pkg::req_id_t rsp_req_id_o,
    output logic rsp_to_req_o,
    output cache_cfg_pkg::line_addr_t rsp_addr_o,
    output cache_cfg_pkg::line_t rsp_line_o,
    output cache_cfg_pkg::word_mask_t rsp_mask_o,
    input  logic fill_valid_i,
    output logic fill_ready_o,
    input  cache_cfg_pkg::line_addr_t fill_addr_i,
    input  cache_cfg_pkg::line_t fill_line_i,
    input  cache_cfg_pkg::line_states_t fill_states_i,
    output logic inval_valid_o,
    output cache_cfg_pkg::line_addr_t inval_addr_o
);

    logic array_ready;

    cache_port_if eng_if ();
    cache_port_if fil_if ();

    cache_arbiter u_arbiter (
        .clk(clk),
        .rst(rst),
        .eng(eng_if.arbiter),
        .fil(fil_if.arbiter),
        .ready_o(array_ready)
    );

    line_filler u_filler (
        .clk(clk),
        .rst(rst),
        .fill_valid_i(fill_valid_i),
        .fill_ready_o(fill_ready_o),
        .fill_addr_i(fill_addr_i),
        .fill_line_i(fill_line_i),
        .fill_states_i(fill_states_i),
        .mem(fil_if.client)
    );

    fwd_engine u_engine (
        .clk(clk),
        .rst(rst),
        .array_ready_i(array_ready),
        .fwd_valid_i(fwd_valid_i),
        .fwd_ready_o(fwd_ready_o),
        .fwd_msg_i(fwd_msg_i),
        .fwd_addr_i(fwd_addr_i),
        .fwd_req_id_i(fwd_req_id_i),
        .fwd_mask_i(fwd_mask_i),
        .fwd_line_i(fwd_line_i),
        .rsp_valid_o(rsp_valid_o),
        .rsp_ready_i(rsp_ready_i),
        .rsp_msg_o(rsp_msg_o),
        .rsp_req_id_o(rsp_req_id_o),
        .rsp_to_req_o(rsp_to_req_o),
        .rsp_addr_o(rsp_addr_o),
        .rsp_line_o(rsp_line_o),
        .rsp_mask_o(rsp_mask_o),
        .inval_valid_o(inval_valid_o),
        .inval_addr_o(inval_addr_o),
        .mem(eng_if.client)
    );

endmodule

// ==== bench/fwd_model.svh ====
`ifndef FWD_MODEL_SVH
`define FWD_MODEL_SVH

typedef struct {
    rsp_msg_t msg;
    req_id_t id;
    logic to_req;
    line_t line;
    word_mask_t mask;
} rsp_rec_t;

l2_tag_t m_tag [l2_sets][l2_ways];
line_states_t m_st [l2_sets][l2_ways];
line_t m_ln [l2_sets][l2_ways];
l2_way_t m_vic [l2_sets];
rsp_rec_t exp_q [$];

function automatic void model_reset();
    for (int s = 0; s < l2_sets; s++) begin
        m_vic[s] = '0;
        for (int w = 0; w < l2_ways; w++) begin
            m_tag[s][w] = '0;
            m_ln[s][w] = '0;
            for (int i = 0; i < words_per_line; i++) m_st[s][w][i] = spx_i;
        end
    end
endfunction

function automatic void model_fill(input line_addr_t a, input line_t ln, input line_states_t st);
    int s;
    s = int'(a[3:0]);
    m_tag[s][m_vic[s]] = a[11:4];
    m_st[s][m_vic[s]] = st;
    m_ln[s][m_vic[s]] = ln;
    m_vic[s] = m_vic[s] + 1'b1; // round robin per set.
endfunction

function automatic void push_exp(input rsp_msg_t msg, input req_id_t id, input logic to_req,
                                 input line_t ln, input word_mask_t mask);
    rsp_rec_t r;
    r.msg = msg;
    r.id = id;
    r.to_req = to_req;
    r.line = ln;
    r.mask = mask;
    exp_q.push_back(r);
endfunction

// returns whether the forward must pulse the L1 invalidation.
function automatic bit model_forward(input fwd_msg_t msg, input line_addr_t a,
                                     input word_mask_t mask, input req_id_t id, input line_t ln);
    int s;
    int hw;
    word_mask_t rm;
    s = int'(a[3:0]);
    hw = -1;
    rm = '0;
    for (int w = l2_ways - 1; w >= 0; w--) begin
        if (m_tag[s][w] == a[11:4] && m_st[s][w] != {words_per_line{spx_i}}) hw = w;
    end
    if (hw >= 0) begin
        for (int i = 0; i < words_per_line; i++) rm[i] = mask[i] && m_st[s][hw][i] == spx_r;
    end
    case (msg)
        fwd_inv_spdx: begin
            for (int i = 0; i < words_per_line; i++) begin
                if (hw >= 0 && mask[i] && m_st[s][hw][i] == spx_s) m_st[s][hw][i] = spx_i;
            end
            push_exp(inv_ack, '0, 1'b0, '0, '1);
        end
        fwd_req_o, fwd_req_odata, fwd_rvk_o: begin
            if (rm != '0) begin
                if (msg == fwd_req_o) push_exp(rsp_o, id, 1'b1, '0, rm);
                else if (msg == fwd_req_odata) push_exp(rsp_odata, id, 1'b1, m_ln[s][hw], rm);
                else push_exp(rsp_rvk_o, id, 1'b0, m_ln[s][hw], rm);
            end
            for (int i = 0; i < words_per_line; i++) begin
                if (rm[i]) m_st[s][hw][i] = spx_i;
            end
        end
        default: begin
            if (rm != '0 && msg == fwd_req_v) push_exp(rsp_v, id, 1'b1, m_ln[s][hw], rm);
            if (rm != '0 && msg == fwd_wtfwd) begin
                push_exp(rsp_o, id, 1'b1, '0, rm);
                for (int i = 0; i < words_per_line; i++) begin
                    if (rm[i]) m_ln[s][hw][i] = ln[i];
                end
            end
            if ((mask & ~rm) != '0) push_exp(rsp_nack, id, 1'b1, '0, mask & ~rm);
            return 1'b0;
        end
    endcase
    return 1'b1;
endfunction

`endif

// ==== bench/tb_l2_fwd.sv ====
module tb_l2_fwd;
    timeunit 1ns;
    timeprecision 100ps;
    import coh_pkg::*;
    import cache_cfg_pkg::*;

    logic clk = 1'b0;
    logic rst = 1'b0;
    logic fwd_valid_i = 1'b0;
    logic fwd_ready_o;
    fwd_msg_t fwd_msg_i = fwd_inv_spdx;
    line_addr_t fwd_addr_i = '0;
    req_id_t fwd_req_id_i = '0;
    word_mask_t fwd_mask_i = '0;
    line_t fwd_line_i = '0;
    logic rsp_valid_o;
    logic rsp_ready_i = 1'b1;
    rsp_msg_t rsp_msg_o;
    req_id_t rsp_req_id_o;
    logic rsp_to_req_o;
    line_addr_t rsp_addr_o;
    line_t rsp_line_o;
    word_mask_t rsp_mask_o;
    logic fill_valid_i = 1'b0;
    logic fill_ready_o;
    line_addr_t fill_addr_i = '0;
    line_t fill_line_i = '0;
    line_states_t fill_states_i = {words_per_line{spx_i}};
    logic inval_valid_o;
    line_addr_t inval_addr_o;

    int errors = 0;
    int checks = 0;
    int tests = 0;
    bit hung = 1'b0;
    logic [31:0] seed = 32'h79b5;
    logic [31:0] bp_seed = 32'h79b5 ^ 32'h00c3_0000;
    logic bp_on = 1'b0;
    line_addr_t filled_q [$];

    `include "fwd_model.svh"

    l2_fwd_top DUT (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // back-pressure on the response port when enabled.
    always @(posedge clk) begin
        if (bp_on) begin
            bp_seed = lcg_step(bp_seed);
            rsp_ready_i <= bp_seed[27] | bp_seed[24];
        end else begin
            rsp_ready_i <= 1'b1;
        end
    end

    function automatic logic [31:0] rand32();
        seed = lcg_step(seed);
        return {seed[15:0], seed[31:16]}; // low bits of the LCG cycle too fast.
    endfunction

    function automatic line_addr_t rand_addr();
        logic [31:0] r;
        l2_tag_t t;
        r = rand32();
        case (r[1:0])
            2'd0: t = 8'h5a;
            2'd1: t = 8'ha5;
            default: t = 8'h3c;
        endcase
        return {t, 2'b00, r[9:8]};
    endfunction

    function automatic line_states_t rand_states();
        logic [31:0] r;
        line_states_t st;
        r = rand32();
        for (int i = 0; i < words_per_line; i++) begin
            case (r[2*i +: 2])
                2'd0: st[i] = spx_i;
                2'd1: st[i] = spx_s;
                default: st[i] = spx_r;
            endcase
        end
        return st;
    endfunction

    function automatic line_t rand_line();
        return {rand32(), rand32(), rand32(), rand32()};
    endfunction

    task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        hung = 1'b1;
    endtask

    task automatic do_fill(input line_addr_t a, input line_t ln, input line_states_t st);
        int n;
        if (hung) return;
        @(posedge clk);
        fill_addr_i <= a;
        fill_line_i <= ln;
        fill_states_i <= st;
        fill_valid_i <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!fill_ready_o && n < 50);
        if (!fill_ready_o) begin
            report_timeout("fill_ready_o");
            return;
        end
        @(posedge clk);
        fill_valid_i <= 1'b0;
        model_fill(a, ln, st);
        @(posedge clk); // the filler writes at this edge.
    endtask

    task automatic do_forward(input fwd_msg_t msg, input line_addr_t a, input word_mask_t mask,
                              input req_id_t id, input line_t ln);
        rsp_rec_t got_q [$];
        rsp_rec_t g;
        bit exp_inval;
        int k;
        int inval_cnt;
        int inval_k;
        if (hung) return;
        exp_q.delete();
        exp_inval = model_forward(msg, a, mask, id, ln);
        k = 0;
        while (!fwd_ready_o && k < 100) begin
            @(negedge clk);
            k++;
        end
        if (!fwd_ready_o) begin
            report_timeout("fwd_ready_o before a forward");
            return;
        end
        @(posedge clk);
        fwd_msg_i <= msg;
        fwd_addr_i <= a;
        fwd_mask_i <= mask;
        fwd_req_id_i <= id;
        fwd_line_i <= ln;
        fwd_valid_i <= 1'b1;
        @(negedge clk);
        if (!fwd_ready_o) begin
            report_timeout("forward acceptance");
            return;
        end
        @(posedge clk);
        fwd_valid_i <= 1'b0;
        k = 0;
        inval_cnt = 0;
        inval_k = 0;
        do begin
            @(negedge clk);
            k++;
            if (inval_valid_o) begin
                inval_cnt++;
                inval_k = k;
                check_val("inval_addr_o", inval_addr_o, a);
            end
            if (rsp_valid_o && rsp_ready_i) begin
                g.msg = rsp_msg_o;
                g.id = rsp_req_id_o;
                g.to_req = rsp_to_req_o;
                g.line = rsp_line_o;
                g.mask = rsp_mask_o;
                got_q.push_back(g);
                check_val("rsp_addr_o", rsp_addr_o, a);
            end
        end while (!fwd_ready_o && k < 400);
        if (!fwd_ready_o) begin
            report_timeout("the end of a forward");
            return;
        end
        checks++;
        assert (got_q.size() == exp_q.size()) else begin
            $display("wrong number of responses for message %0d: got %0d, expected %0d",
                     msg, got_q.size(), exp_q.size());
            errors++;
        end
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            check_val("rsp_msg_o", got_q[i].msg, exp_q[i].msg);
            check_val("rsp_req_id_o", got_q[i].id, exp_q[i].id);
            check_val("rsp_to_req_o", got_q[i].to_req, exp_q[i].to_req);
            check_val("rsp_line_o", got_q[i].line, exp_q[i].line);
            check_val("rsp_mask_o", got_q[i].mask, exp_q[i].mask);
        end
        checks++;
        if (exp_inval) begin
            assert (inval_cnt == 1 && inval_k == 3) else begin
                $display("invalidation pulsed %0d times, last in cycle %0d, expected once in 3",
                         inval_cnt, inval_k);
                errors++;
            end
        end else begin
            assert (inval_cnt == 0) else begin
                $display("invalidation pulsed for message %0d, which must not invalidate", msg);
                errors++;
            end
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        $display("test %0d %s: %s, %0d errors", tests, name,
                 errors == err_before ? "ok" : "failed", errors - err_before);
    endtask

    initial begin
        int n;
        int e0;
        logic [31:0] r;
        line_addr_t a;
        model_reset();
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        fill_valid_i <= 1'b1; // this fill is held off until the sweep is over.

        e0 = errors;
        n = 0;
        do begin
            @(negedge clk);
            if (!fwd_ready_o) begin
                n++;
                check_val("fill_ready_o", fill_ready_o, 1'b0);
                check_val("rsp_valid_o", rsp_valid_o, 1'b0);
                check_val("inval_valid_o", inval_valid_o, 1'b0);
            end
        end while (!fwd_ready_o && n < 100);
        if (!fwd_ready_o) begin
            report_timeout("the reset sweep");
        end else begin
            check_val("sweep cycles", n, l2_sets);
            check_val("fill_ready_o", fill_ready_o, 1'b1);
            @(posedge clk);
            fill_valid_i <= 1'b0;
            model_fill(fill_addr_i, fill_line_i, fill_states_i);
            @(posedge clk); // the filler writes at this edge.
        end
        for (int m = 0; m < 6; m++) begin
            r = rand32();
            do_forward(fwd_msg_t'(m), rand_addr(), r[3:0], r[7:4], rand_line());
        end
        end_test("reset sweep and misses", e0);

        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            a = rand_addr();
            do_fill(a, rand_line(), rand_states());
            filled_q.push_back(a);
        end
        for (int i = 0; i < 8; i++) begin
            r = rand32();
            repeat (2) do_forward(r[0] ? fwd_req_odata : fwd_rvk_o, filled_q[i],
                                  r[1] ? 4'hf : r[7:4], r[11:8], '0);
        end
        end_test("owned forwards", e0);

        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            do_fill(filled_q[i], rand_line(), rand_states());
            r = rand32();
            do_forward(fwd_req_v, filled_q[i], r[3:0], r[7:4], '0);
            do_forward(fwd_wtfwd, filled_q[i], r[11:8], r[15:12], rand_line());
            do_forward(fwd_req_odata, filled_q[i], 4'hf, r[19:16], '0);
        end
        end_test("ack and nack split", e0);

        e0 = errors;
        for (int i = 0; i < 12; i++) begin
            r = rand32();
            do_forward(fwd_msg_t'(3'(r % 6)), filled_q[i % 8], r[11:8], r[15:12], rand_line());
        end
        end_test("invalidation timing", e0);

        e0 = errors;
        bp_on = 1'b1;
        for (int i = 0; i < 300; i++) begin
            r = rand32();
            if (r[1:0] == 2'd0) begin
                do_fill(rand_addr(), rand_line(), rand_states());
            end else begin
                do_forward(fwd_msg_t'(3'(r[31:8] % 6)), rand_addr(), r[7:4], r[11:8],
                           rand_line());
            end
        end
        bp_on = 1'b0;
        end_test("random mix", e0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !hung) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
design/coh_pkg.sv
design/cache_cfg_pkg.sv
design/cache_port_if.sv
design/sram_bank.sv
design/cache_arbiter.sv
design/line_filler.sv
design/fwd_engine.sv
design/l2_fwd_top.sv
+incdir+bench
bench/tb_l2_fwd.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line in the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f compile.f --top-module tb_l2_fwd \
    -Mdir obj_dir -o sim_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" sim.log; then
    exit 0
fi
exit 1
